// ==== hw/natv_pkg.sv ====
/*
 * native bus peripheral package
 * bus structs, address map, register offsets and the byte strobe merge
 */
package natv_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } nmi_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } nmi_rsp_t;

  // index into the decoder select vector
  typedef enum logic [2:0] {
    SLV_GPIO,
    SLV_TIM0,
    SLV_TIM1,
    SLV_CLINT,
    SLV_MISS
  } slave_e;

  localparam int NUM_SLV = 4;
  localparam int GPIO_W  = 8;
  localparam int IRQ_W   = 4;

  // addr[31:28] region, addr[15:8] slave code
  localparam logic [3:0] NATV_REGION = 4'h1;
  localparam logic [7:0] GPIO_BASE   = 8'h00;
  localparam logic [7:0] TIM0_BASE   = 8'h01;
  localparam logic [7:0] TIM1_BASE   = 8'h02;
  localparam logic [7:0] CLINT_BASE  = 8'h03;

  // register offsets on addr[3:2]
  localparam logic [1:0] GPIO_OUT       = 2'd0;
  localparam logic [1:0] GPIO_OE        = 2'd1;
  localparam logic [1:0] GPIO_IN        = 2'd2;
  localparam logic [1:0] TIM_CTRL       = 2'd0;
  localparam logic [1:0] TIM_CMP        = 2'd1;
  localparam logic [1:0] TIM_CNT        = 2'd2;
  localparam logic [1:0] TIM_STAT       = 2'd3;
  localparam logic [1:0] CLINT_MSIP     = 2'd0;
  localparam logic [1:0] CLINT_MTIME    = 2'd1;
  localparam logic [1:0] CLINT_MTIMECMP = 2'd2;

  // replace only the strobed bytes of old_d
  function automatic logic [31:0] merge_wstrb(logic [31:0] old_d, logic [31:0] new_d,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old_d;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i+:8] = new_d[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage

// ==== hw/natv_decoder.sv ====
/*
 * native bus address decoder
 * one-hot slave select from the request address, plus a miss bit
 */
module natv_decoder (
  input  logic                       clk_i,
  input  natv_pkg::nmi_req_t         req_i,
  output logic [natv_pkg::NUM_SLV:0] sel_o
);
  import natv_pkg::*;

  logic       region_hit;
  logic [7:0] slv_code;

  assign region_hit = (req_i.addr[31:28] == NATV_REGION);
  assign slv_code   = req_i.addr[15:8];

  always_comb begin
    sel_o = '0;
    if (region_hit) begin
      case (slv_code)
        GPIO_BASE:  sel_o[SLV_GPIO]  = 1'b1;
        TIM0_BASE:  sel_o[SLV_TIM0]  = 1'b1;
        TIM1_BASE:  sel_o[SLV_TIM1]  = 1'b1;
        CLINT_BASE: sel_o[SLV_CLINT] = 1'b1;
        default:    sel_o = '0;
      endcase
    end
    // miss only for a live request nobody claims
    sel_o[SLV_MISS] = req_i.valid & ~(|sel_o[NUM_SLV-1:0]);
  end

  sel_onehot_a : assert property (@(posedge clk_i) $onehot0(sel_o))
    else $error("decoder select is not one-hot");

endmodule

// ==== hw/natv_gpio.sv ====
/*
 * GPIO slave
 * output and output-enable registers, synchronized input register
 */
module natv_gpio (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  natv_pkg::nmi_req_t          req_i,
  input  logic                        sel_i,
  output natv_pkg::nmi_rsp_t          rsp_o,
  input  logic [natv_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [natv_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [natv_pkg::GPIO_W-1:0] gpio_oe_o
);
  import natv_pkg::*;

  logic              acc;
  logic              wr;
  logic              ready_q;
  logic [31:0]       rdata_q;
  logic [31:0]       rd_val;
  logic [31:0]       out_merged;
  logic [31:0]       oe_merged;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] in_q;

  assign acc        = req_i.valid & sel_i & ~ready_q;
  assign wr         = acc & (|req_i.wstrb);
  assign out_merged = merge_wstrb(32'(out_q), req_i.wdata, req_i.wstrb);
  assign oe_merged  = merge_wstrb(32'(oe_q), req_i.wdata, req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      out_q   <= '0;
      oe_q    <= '0;
    end else begin
      ready_q <= acc;
      if (wr && req_i.addr[3:2] == GPIO_OUT) begin
        out_q <= out_merged[GPIO_W-1:0];
      end
      if (wr && req_i.addr[3:2] == GPIO_OE) begin
        oe_q <= oe_merged[GPIO_W-1:0];
      end
    end
  end

  // pins are asynchronous
  always_ff @(posedge clk_i) begin
    sync1_q <= gpio_in_i;
    sync2_q <= sync1_q;
    in_q    <= sync2_q;
  end

  always_comb begin
    case (req_i.addr[3:2])
      GPIO_OUT: rd_val = 32'(out_q);
      GPIO_OE:  rd_val = 32'(oe_q);
      GPIO_IN:  rd_val = 32'(in_q);
      default:  rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_q <= rd_val;
    end
  end

  assign rsp_o      = '{ready: ready_q, rdata: rdata_q};
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = oe_q;

endmodule

// ==== hw/natv_timer.sv ====
/*
 * compare timer slave
 * counts up to CMP, wraps to zero and sets a sticky match flag
 */
module natv_timer (
  input  logic               clk_i,
  input  logic               rst_i,
  input  natv_pkg::nmi_req_t req_i,
  input  logic               sel_i,
  output natv_pkg::nmi_rsp_t rsp_o,
  output logic               irq_o
);
  import natv_pkg::*;

  logic        acc;
  logic        wr;
  logic        en;
  logic        ie;
  logic        hit;
  logic        ready_q;
  logic [1:0]  ctrl_q;
  logic [31:0] cmp_q;
  logic [31:0] cnt_q;
  logic        match_q;
  logic [31:0] rd_val;
  logic [31:0] rdata_q;

  assign acc = req_i.valid & sel_i & ~ready_q;
  assign wr  = acc & (|req_i.wstrb);
  assign en  = ctrl_q[0];
  assign ie  = ctrl_q[1];
  assign hit = en & (cnt_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      ctrl_q  <= '0;
      cmp_q   <= '0;
      cnt_q   <= '0;
      match_q <= 1'b0;
    end else begin
      ready_q <= acc;
      if (hit) begin
        cnt_q <= '0;
      end else if (en) begin
        cnt_q <= cnt_q + 32'd1;
      end
      if (wr) begin
        case (req_i.addr[3:2])
          TIM_CTRL: begin
            if (req_i.wstrb[0]) begin
              ctrl_q <= req_i.wdata[1:0];
            end
          end
          TIM_CMP: begin
            cmp_q <= merge_wstrb(cmp_q, req_i.wdata, req_i.wstrb);
            // restart so the count never sits above a new compare
            cnt_q <= '0;
          end
          TIM_STAT: begin
            if (req_i.wstrb[0] && req_i.wdata[0]) begin
              match_q <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      // a new match wins over a clear in the same cycle
      if (hit) begin
        match_q <= 1'b1;
      end
    end
  end

  always_comb begin
    case (req_i.addr[3:2])
      TIM_CTRL: rd_val = {30'd0, ctrl_q};
      TIM_CMP:  rd_val = cmp_q;
      TIM_CNT:  rd_val = cnt_q;
      TIM_STAT: rd_val = {31'd0, match_q};
      default:  rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_q <= rd_val;
    end
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};
  assign irq_o = match_q & ie;

  cnt_bound_a : assert property (@(posedge clk_i) disable iff (rst_i) en |-> cnt_q <= cmp_q)
    else $error("timer count above compare value");

endmodule

// ==== hw/natv_clint.sv ====
/*
 * core-local interrupt unit
 * software interrupt bit, free-running mtime and mtimecmp
 */
module natv_clint (
  input  logic               clk_i,
  input  logic               rst_i,
  input  natv_pkg::nmi_req_t req_i,
  input  logic               sel_i,
  output natv_pkg::nmi_rsp_t rsp_o,
  output logic               sfr_irq_o,
  output logic               tmr_irq_o
);
  import natv_pkg::*;

  logic        acc;
  logic        wr;
  logic        ready_q;
  logic        msip_q;
  logic [31:0] mtime_q;
  logic [31:0] mtimecmp_q;
  logic [31:0] rd_val;
  logic [31:0] rdata_q;

  assign acc = req_i.valid & sel_i & ~ready_q;
  assign wr  = acc & (|req_i.wstrb);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q    <= 1'b0;
      msip_q     <= 1'b0;
      mtime_q    <= '0;
      // all ones keeps the timer irq quiet until programmed
      mtimecmp_q <= '1;
    end else begin
      ready_q <= acc;
      if (wr && req_i.addr[3:2] == CLINT_MTIME) begin
        mtime_q <= merge_wstrb(mtime_q, req_i.wdata, req_i.wstrb);
      end else begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr && req_i.addr[3:2] == CLINT_MTIMECMP) begin
        mtimecmp_q <= merge_wstrb(mtimecmp_q, req_i.wdata, req_i.wstrb);
      end
      if (wr && req_i.addr[3:2] == CLINT_MSIP && req_i.wstrb[0]) begin
        msip_q <= req_i.wdata[0];
      end
    end
  end

  always_comb begin
    case (req_i.addr[3:2])
      CLINT_MSIP:     rd_val = {31'd0, msip_q};
      CLINT_MTIME:    rd_val = mtime_q;
      CLINT_MTIMECMP: rd_val = mtimecmp_q;
      default:        rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      rdata_q <= rd_val;
    end
  end

  assign rsp_o     = '{ready: ready_q, rdata: rdata_q};
  assign sfr_irq_o = msip_q;
  assign tmr_irq_o = (mtime_q >= mtimecmp_q);

endmodule

// ==== hw/natv_rsp_mux.sv ====
/*
 * response mux
 * merges slave responses, answers unmapped accesses, packs the irq vector
 */
module natv_rsp_mux (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [natv_pkg::NUM_SLV:0] sel_i,
  input  natv_pkg::nmi_rsp_t         gpio_rsp_i,
  input  natv_pkg::nmi_rsp_t         tim0_rsp_i,
  input  natv_pkg::nmi_rsp_t         tim1_rsp_i,
  input  natv_pkg::nmi_rsp_t         clint_rsp_i,
  input  logic                       clint_sfr_irq_i,
  input  logic                       clint_tmr_irq_i,
  input  logic                       tim0_irq_i,
  input  logic                       tim1_irq_i,
  output natv_pkg::nmi_rsp_t         rsp_o,
  output logic [natv_pkg::IRQ_W-1:0] irq_o
);
  import natv_pkg::*;

  logic               miss_ready_q;
  logic [NUM_SLV:0]   rdy_vec;
  logic [NUM_SLV:0]   hit_vec;

  // unmapped access gets a one-cycle ready with zero data
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      miss_ready_q <= 1'b0;
    end else begin
      miss_ready_q <= sel_i[SLV_MISS] & ~miss_ready_q;
    end
  end

  always_comb begin
    rdy_vec            = '0;
    rdy_vec[SLV_GPIO]  = gpio_rsp_i.ready;
    rdy_vec[SLV_TIM0]  = tim0_rsp_i.ready;
    rdy_vec[SLV_TIM1]  = tim1_rsp_i.ready;
    rdy_vec[SLV_CLINT] = clint_rsp_i.ready;
    rdy_vec[SLV_MISS]  = miss_ready_q;
  end

  assign hit_vec = rdy_vec & sel_i;

  assign rsp_o.ready = |hit_vec;
  assign rsp_o.rdata = ({32{hit_vec[SLV_GPIO]}}  & gpio_rsp_i.rdata) |
                       ({32{hit_vec[SLV_TIM0]}}  & tim0_rsp_i.rdata) |
                       ({32{hit_vec[SLV_TIM1]}}  & tim1_rsp_i.rdata) |
                       ({32{hit_vec[SLV_CLINT]}} & clint_rsp_i.rdata);

  assign irq_o = {tim1_irq_i, tim0_irq_i, clint_tmr_irq_i, clint_sfr_irq_i};

  rdy_onehot_a : assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(rdy_vec))
    else $error("more than one slave ready");

endmodule

// ==== hw/natv_periph_top.sv ====
/*
 * native bus peripheral block
 * decoder, GPIO, two timers, CLINT and response mux
 */
module natv_periph_top (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  natv_pkg::nmi_req_t          req_i,
  output natv_pkg::nmi_rsp_t          rsp_o,
  input  logic [natv_pkg::GPIO_W-1:0] gpio_in_i,
  output logic [natv_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [natv_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic [natv_pkg::IRQ_W-1:0]  irq_o
);
  import natv_pkg::*;

  logic [NUM_SLV:0] sel;
  nmi_rsp_t         gpio_rsp;
  nmi_rsp_t         tim0_rsp;
  nmi_rsp_t         tim1_rsp;
  nmi_rsp_t         clint_rsp;
  logic             tim0_irq;
  logic             tim1_irq;
  logic             clint_sfr_irq;
  logic             clint_tmr_irq;

  natv_decoder u_decoder (
    .clk_i (clk_i),
    .req_i (req_i),
    .sel_o (sel)
  );

  natv_gpio u_gpio (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .sel_i      (sel[SLV_GPIO]),
    .rsp_o      (gpio_rsp),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

  natv_timer u_tim0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (req_i),
    .sel_i (sel[SLV_TIM0]),
    .rsp_o (tim0_rsp),
    .irq_o (tim0_irq)
  );

  natv_timer u_tim1 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (req_i),
    .sel_i (sel[SLV_TIM1]),
    .rsp_o (tim1_rsp),
    .irq_o (tim1_irq)
  );

  natv_clint u_clint (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .sel_i     (sel[SLV_CLINT]),
    .rsp_o     (clint_rsp),
    .sfr_irq_o (clint_sfr_irq),
    .tmr_irq_o (clint_tmr_irq)
  );

  natv_rsp_mux u_rsp_mux (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .sel_i           (sel),
    .gpio_rsp_i      (gpio_rsp),
    .tim0_rsp_i      (tim0_rsp),
    .tim1_rsp_i      (tim1_rsp),
    .clint_rsp_i     (clint_rsp),
    .clint_sfr_irq_i (clint_sfr_irq),
    .clint_tmr_irq_i (clint_tmr_irq),
    .tim0_irq_i      (tim0_irq),
    .tim1_irq_i      (tim1_irq),
    .rsp_o           (rsp_o),
    .irq_o           (irq_o)
  );

endmodule

// ==== verif/tb_clk_gen.sv ====
/*
 * testbench clock generator
 * free-running clock with a 40 ns period
 */
module tb_clk_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

endmodule

// ==== verif/natv_tb.sv ====
/*
 * testbench for the native bus peripheral block
 * bus accesses to every slave, interrupt timing and handshake assertions
 */
module natv_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import natv_pkg::*;

  localparam int WD_CYCLES = 600;

  logic              clk;
  logic              rst;
  nmi_req_t          req;
  nmi_rsp_t          rsp;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic [IRQ_W-1:0]  irq;
  logic              rdy;
  int                seed = 32'hb2cc_0e2c;
  int                cyc = 0;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  natv_periph_top dut (
    .clk_i      (clk),
    .rst_i      (rst),
    .req_i      (req),
    .rsp_o      (rsp),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .irq_o      (irq)
  );

  assign rdy = rsp.ready;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else fail_now($sformatf("Error: %s expected 0x%08h actual 0x%08h", name, exp, act));
  endtask

  function automatic logic [31:0] addr_of(input logic [7:0] base, input logic [1:0] off);
    return {NATV_REGION, 12'h000, base, 4'h0, off, 2'b00};
  endfunction

  // bytes with a strobe take the new data
  function automatic logic [31:0] apply_byte_mask(input logic [31:0] old_d,
                                                  input logic [31:0] new_d,
                                                  input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_d & ~mask) | (new_d & mask);
  endfunction

  function automatic logic stat_write(input nmi_req_t r, input logic [7:0] base);
    return r.valid && (|r.wstrb) && (r.addr == addr_of(base, TIM_STAT));
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    waited = 0;
    req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    @(negedge clk);
    waited = 1;
    while (rsp.ready !== 1'b1) begin
      if (waited >= 8) begin
        fail_now("bus access got no ready within 8 cycles");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    check_val("handshake latency", 1, waited);
    rdata = rsp.rdata;
    @(negedge clk);
    req = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused;
    bus_access(addr, data, strb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'd0, 4'h0, data);
  endtask

  task automatic wait_irq(input int idx, input int max_cyc, input string name);
    int n;
    n = 0;
    while (irq[idx] !== 1'b1) begin
      if (n == max_cyc) begin
        fail_now($sformatf("%s interrupt did not rise within %0d cycles", name, max_cyc));
      end else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic run_timer(input logic [7:0] base, input int idx, input int n,
                           input string name);
    logic [31:0] rd;
    bus_write(addr_of(base, TIM_CMP), n, 4'hf);
    bus_write(addr_of(base, TIM_CTRL), 32'd3, 4'hf);
    wait_irq(idx, n + 2, name);
    // sticky until cleared
    repeat (4) begin
      @(negedge clk);
      check_val({name, " irq held"}, 1, irq[idx]);
    end
    bus_write(addr_of(base, TIM_CTRL), 32'd2, 4'hf);
    check_val({name, " irq after disable"}, 1, irq[idx]);
    bus_write(addr_of(base, TIM_STAT), 32'd1, 4'hf);
    check_val({name, " irq after clear"}, 0, irq[idx]);
    // counting with the interrupt masked
    bus_write(addr_of(base, TIM_CTRL), 32'd1, 4'hf);
    repeat (2 * n + 4) begin
      @(negedge clk);
      check_val({name, " irq masked"}, 0, irq[idx]);
    end
    bus_read(addr_of(base, TIM_STAT), rd);
    check_val({name, " match flag"}, 1, rd);
    bus_write(addr_of(base, TIM_CTRL), 32'd0, 4'hf);
    bus_write(addr_of(base, TIM_STAT), 32'd1, 4'hf);
  endtask

  ready_follows_valid_a : assert property (@(posedge clk) disable iff (rst)
    req.valid && !rdy |=> rdy)
    else fail_now("ready did not follow valid after one cycle");

  ready_one_cycle_a : assert property (@(posedge clk) disable iff (rst) rdy |=> !rdy)
    else fail_now("ready stayed high for more than one cycle");

  ready_needs_valid_a : assert property (@(posedge clk) disable iff (rst) rdy |-> req.valid)
    else fail_now("ready was raised without a request");

  tim0_irq_hold_a : assert property (@(posedge clk) disable iff (rst)
    $fell(irq[2]) |-> $past(stat_write(req, TIM0_BASE)))
    else fail_now("timer 0 interrupt fell without a STAT write");

  tim1_irq_hold_a : assert property (@(posedge clk) disable iff (rst)
    $fell(irq[3]) |-> $past(stat_write(req, TIM1_BASE)))
    else fail_now("timer 1 interrupt fell without a STAT write");

  initial begin
    #(WD_CYCLES * 40ns);
    fail_now("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] d;
    logic [31:0] rd;
    logic [31:0] old;
    int          c0;
    int          elapsed;
    rst     = 1'b1;
    req     = '0;
    gpio_in = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_val("reset ready", 0, rsp.ready);
    check_val("reset gpio_out", 0, gpio_out);
    check_val("reset gpio_oe", 0, gpio_oe);
    check_val("reset irq", 0, irq);

    // one read per slave, then unmapped slave code and region
    bus_read(addr_of(GPIO_BASE, GPIO_OUT), rd);
    check_val("gpio out after reset", 0, rd);
    bus_read(addr_of(TIM0_BASE, TIM_CTRL), rd);
    check_val("tim0 ctrl after reset", 0, rd);
    bus_read(addr_of(TIM1_BASE, TIM_CNT), rd);
    check_val("tim1 cnt after reset", 0, rd);
    bus_read(addr_of(CLINT_BASE, CLINT_MSIP), rd);
    check_val("clint msip after reset", 0, rd);
    bus_read(addr_of(8'h07, 2'd0), rd);
    check_val("unmapped slave read", 0, rd);
    bus_read(32'h2000_0104, rd);
    check_val("unmapped region read", 0, rd);

    d = $random(seed);
    bus_write(addr_of(GPIO_BASE, GPIO_OUT), d, 4'hf);
    check_val("gpio_out pins", d[7:0], gpio_out);
    bus_read(addr_of(GPIO_BASE, GPIO_OUT), rd);
    check_val("gpio out readback", {24'd0, d[7:0]}, rd);
    d = $random(seed);
    bus_write(addr_of(GPIO_BASE, GPIO_OE), d, 4'hf);
    check_val("gpio_oe pins", d[7:0], gpio_oe);
    bus_read(addr_of(GPIO_BASE, GPIO_OE), rd);
    check_val("gpio oe readback", {24'd0, d[7:0]}, rd);
    gpio_in = $random(seed);
    repeat (3) @(negedge clk);
    bus_read(addr_of(GPIO_BASE, GPIO_IN), rd);
    check_val("gpio in readback", {24'd0, gpio_in}, rd);

    // partial strobes on OUT and on a timer compare register
    old = {24'd0, gpio_out};
    d   = $random(seed);
    bus_write(addr_of(GPIO_BASE, GPIO_OUT), d, 4'b1110);
    check_val("gpio strobe upper", apply_byte_mask(old, d, 4'b1110) & 32'hff, gpio_out);
    d = $random(seed);
    bus_write(addr_of(GPIO_BASE, GPIO_OUT), d, 4'b0001);
    check_val("gpio strobe lower", apply_byte_mask(old, d, 4'b0001) & 32'hff, gpio_out);
    bus_write(addr_of(TIM1_BASE, TIM_CMP), 32'h1122_3344, 4'hf);
    d = $random(seed);
    bus_write(addr_of(TIM1_BASE, TIM_CMP), d, 4'b0101);
    bus_read(addr_of(TIM1_BASE, TIM_CMP), rd);
    check_val("timer cmp strobe", apply_byte_mask(32'h1122_3344, d, 4'b0101), rd);

    run_timer(TIM0_BASE, 2, 10, "timer 0");
    run_timer(TIM1_BASE, 3, 6, "timer 1");

    bus_write(addr_of(CLINT_BASE, CLINT_MSIP), 32'd1, 4'hf);
    check_val("clint msip set", 1, irq[0]);
    bus_write(addr_of(CLINT_BASE, CLINT_MSIP), 32'd0, 4'hf);
    check_val("clint msip clear", 0, irq[0]);
    check_val("clint timer idle", 0, irq[1]);
    c0 = cyc;
    bus_read(addr_of(CLINT_BASE, CLINT_MTIME), rd);
    bus_write(addr_of(CLINT_BASE, CLINT_MTIMECMP), rd + 32'd20, 4'hf);
    wait_irq(1, 22, "clint timer");
    elapsed = cyc - c0;
    assert (elapsed >= 18 && elapsed <= 22)
      else fail_now($sformatf("Error: clint timer irq expected 18 to 22 actual %0d", elapsed));

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/natv_pkg.sv
hw/natv_decoder.sv
hw/natv_gpio.sv
hw/natv_timer.sv
hw/natv_clint.sv
hw/natv_rsp_mux.sv
hw/natv_periph_top.sv
verif/tb_clk_gen.sv
verif/natv_tb.sv
